/* design/i2c_pkg.sv */
`default_nettype none

package i2c_pkg;

	// Clock cycles per SCL phase, kept as one byte wide word for the phase counter
	localparam logic [7:0] half_bit = 8'd16;

	// Cycles that SDA is pushed high before the pad is released
	localparam logic [3:0] release_hold = 4'd12;

	// Address enable table, each row covers eight consecutive addresses
	localparam int addr_rows = 16;
	localparam int row_bits = 8;

	// Width of the acknowledged byte counter reported to the host
	localparam int count_bits = 8;

	typedef enum logic [3:0] {
		idle,
		tx_start,
		tx_bit_low,
		tx_bit_high,
		tx_ack_low,
		tx_ack_high,
		tx_wait_byte,
		tx_stop_a,
		tx_stop_b,
		tx_stop_c,
		tx_result,
		rx_bit,
		rx_ack,
		rx_hold
	} ctrl_state_e;

	typedef enum logic {
		res_ack,
		res_nak
	} result_e;

endpackage

`default_nettype wire

/* design/line_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module line_sampler (
	input wire clk,
	input wire reset,
	input wire scl_pin,
	input wire sda_pin,
	output logic scl_now,
	output logic sda_now,
	output logic scl_rise,
	output logic scl_fall,
	output logic start_seen,
	output logic stop_seen
);

	logic scl_meta;
	logic sda_meta;
	logic scl_prev;
	logic sda_prev;

	// Idle bus is high on both lines, so the stages come out of reset high
	always_ff @(posedge clk) begin
		if (reset) begin
			scl_meta <= 1'b1;
			sda_meta <= 1'b1;
			scl_now <= 1'b1;
			sda_now <= 1'b1;
			scl_prev <= 1'b1;
			sda_prev <= 1'b1;
			scl_rise <= 1'b0;
			scl_fall <= 1'b0;
			start_seen <= 1'b0;
			stop_seen <= 1'b0;
		end else begin
			scl_meta <= scl_pin;
			sda_meta <= sda_pin;
			scl_now <= scl_meta;
			sda_now <= sda_meta;
			scl_prev <= scl_now;
			sda_prev <= sda_now;
			scl_rise <= scl_now & ~scl_prev;
			scl_fall <= ~scl_now & scl_prev;
			// SDA moving while SCL stays high marks a frame boundary
			start_seen <= scl_now & scl_prev & ~sda_now & sda_prev;
			stop_seen <= scl_now & scl_prev & sda_now & ~sda_prev;
		end
	end

endmodule

`default_nettype wire

/* design/bit_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_timer (
	input wire clk,
	input wire reset,
	input wire phase_restart,
	output logic phase_end,
	output logic phase_quarter
);

	logic [$bits(i2c_pkg::half_bit)-1:0] count;

	// The counter stops on the last cycle of a phase, so a state that waits
	// past its phase keeps phase_end and phase_quarter set
	always_ff @(posedge clk) begin
		if (reset || phase_restart) begin
			count <= '0;
		end else if (!phase_end) begin
			count <= count + 1'b1;
		end
	end

	assign phase_end = (count == i2c_pkg::half_bit - 1'b1);
	assign phase_quarter = (count >= (i2c_pkg::half_bit >> 2));

endmodule

`default_nettype wire

/* design/byte_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_shifter (
	input wire clk,
	input wire reset,
	input wire load_tx,
	input wire [7:0] tx_byte,
	input wire shift_tx,
	input wire shift_rx,
	input wire count_clear,
	input wire sda_now,
	output logic tx_bit,
	output logic [7:0] rx_byte,
	output logic [2:0] bit_index
);

	logic [7:0] tx_shift;

	// Both directions move MSB first
	always_ff @(posedge clk) begin
		if (load_tx) begin
			tx_shift <= tx_byte;
		end else if (shift_tx) begin
			tx_shift <= {tx_shift[6:0], 1'b0};
		end
		if (shift_rx) begin
			rx_byte <= {rx_byte[6:0], sda_now};
		end
	end

	// Only one direction is active at a time, so one counter serves both
	always_ff @(posedge clk) begin
		if (reset || count_clear) begin
			bit_index <= 3'd0;
		end else if (shift_tx || shift_rx) begin
			bit_index <= bit_index + 3'd1;
		end
	end

	assign tx_bit = tx_shift[7];

endmodule

`default_nettype wire

/* design/addr_table.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_table (
	input wire clk,
	input wire reset,
	input wire cfg_req,
	input wire [$clog2(i2c_pkg::addr_rows)-1:0] cfg_row,
	input wire [i2c_pkg::row_bits-1:0] cfg_data,
	input wire [6:0] lookup_addr,
	output logic cfg_ack,
	output logic addr_enabled
);

	logic [i2c_pkg::row_bits-1:0] rows [i2c_pkg::addr_rows];

	// A row is written on the same edge that raises cfg_ack
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_ack <= 1'b0;
			for (int i = 0; i < i2c_pkg::addr_rows; i++) begin
				rows[i] <= '0;
			end
		end else begin
			if (cfg_req && !cfg_ack) begin
				rows[cfg_row] <= cfg_data;
				cfg_ack <= 1'b1;
			end else if (!cfg_req) begin
				cfg_ack <= 1'b0;
			end
		end
	end

	// Upper address bits pick the row and the low three pick the bit in it
	assign addr_enabled = rows[lookup_addr[6:3]][lookup_addr[2:0]];

endmodule

`default_nettype wire

/* design/pad_driver.sv */
`timescale 1ns/1ps
`default_nettype none

module pad_driver (
	input wire clk,
	input wire reset,
	input wire scl_drive,
	input wire scl_level,
	input wire sda_drive,
	input wire sda_level,
	input wire ack_hold,
	input wire phase_quarter,
	output logic scl_pd,
	output logic scl_pu,
	output logic scl_tri,
	output logic sda_pd,
	output logic sda_pu,
	output logic sda_tri
);

	logic [$bits(i2c_pkg::release_hold)-1:0] rel_count;

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_pd <= 1'b0;
			scl_pu <= 1'b0;
			scl_tri <= 1'b0;
		end else begin
			scl_pd <= scl_drive & ~scl_level;
			scl_pu <= scl_drive & scl_level;
			scl_tri <= scl_drive;
		end
	end

	// SDA changes wait for the quarter point so they never land on an SCL edge
	always_ff @(posedge clk) begin
		if (reset) begin
			sda_pd <= 1'b0;
			sda_pu <= 1'b0;
			sda_tri <= 1'b0;
			rel_count <= i2c_pkg::release_hold;
		end else if (ack_hold) begin
			sda_pd <= 1'b1;
			sda_pu <= 1'b0;
			sda_tri <= 1'b1;
		end else if (sda_drive) begin
			rel_count <= '0;
			if (phase_quarter) begin
				sda_pd <= ~sda_level;
				sda_pu <= sda_level;
				sda_tri <= 1'b1;
			end
		end else if (rel_count != i2c_pkg::release_hold) begin
			// Push the line high for a while before letting go of it
			if (phase_quarter) begin
				sda_pd <= 1'b0;
				sda_pu <= 1'b1;
				sda_tri <= 1'b1;
				rel_count <= rel_count + 1'b1;
			end
		end else begin
			sda_pd <= 1'b0;
			sda_pu <= 1'b0;
			sda_tri <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/i2c_control.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_control (
	input wire clk,
	input wire reset,
	input wire tx_req,
	input wire [7:0] tx_data,
	input wire tx_last,
	input wire result_ack,
	input wire rx_ack,
	input wire scl_now,
	input wire sda_now,
	input wire scl_rise,
	input wire scl_fall,
	input wire start_seen,
	input wire stop_seen,
	input wire phase_end,
	input wire phase_quarter,
	input wire tx_bit,
	input wire [7:0] rx_byte,
	input wire [2:0] bit_index,
	input wire addr_enabled,
	output logic tx_ack,
	output logic result_req,
	output i2c_pkg::result_e result_code,
	output logic [i2c_pkg::count_bits-1:0] result_count,
	output logic rx_req,
	output logic [7:0] rx_data,
	output logic rx_first,
	output logic phase_restart,
	output logic load_tx,
	output logic [7:0] tx_byte,
	output logic shift_tx,
	output logic shift_rx,
	output logic count_clear,
	output logic scl_drive,
	output logic scl_level,
	output logic sda_drive,
	output logic sda_level,
	output logic ack_hold,
	output logic [6:0] lookup_addr
);

	i2c_pkg::ctrl_state_e state;
	i2c_pkg::ctrl_state_e state_next;

	logic start_half;
	logic last_q;
	logic nak_q;
	logic [i2c_pkg::count_bits-1:0] ack_count;
	logic first_q;
	logic matched_q;
	logic ack_phase;
	logic byte_done;

	always_comb begin
		state_next = state;
		load_tx = 1'b0;
		shift_tx = 1'b0;
		shift_rx = 1'b0;
		count_clear = 1'b0;
		scl_drive = 1'b0;
		scl_level = 1'b1;
		sda_drive = 1'b0;
		sda_level = 1'b1;

		case (state)
			i2c_pkg::idle: begin
				// A remote START wins over a pending host frame
				if (start_seen) begin
					count_clear = 1'b1;
					state_next = i2c_pkg::rx_bit;
				end else if (tx_req && !tx_ack && phase_quarter && scl_now && sda_now) begin
					load_tx = 1'b1;
					count_clear = 1'b1;
					state_next = i2c_pkg::tx_start;
				end
			end
			i2c_pkg::tx_start: begin
				// First phase holds SDA high, second pulls it low under a high SCL
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				sda_level = !start_half;
				if (phase_end && start_half) begin
					state_next = i2c_pkg::tx_bit_low;
				end
			end
			i2c_pkg::tx_bit_low: begin
				scl_drive = 1'b1;
				scl_level = 1'b0;
				sda_drive = 1'b1;
				sda_level = tx_bit;
				if (phase_end) begin
					state_next = i2c_pkg::tx_bit_high;
				end
			end
			i2c_pkg::tx_bit_high: begin
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				sda_level = tx_bit;
				if (phase_end) begin
					shift_tx = 1'b1;
					if (bit_index == 3'd7) begin
						state_next = i2c_pkg::tx_ack_low;
					end else begin
						state_next = i2c_pkg::tx_bit_low;
					end
				end
			end
			i2c_pkg::tx_ack_low: begin
				scl_drive = 1'b1;
				scl_level = 1'b0;
				if (phase_end) begin
					state_next = i2c_pkg::tx_ack_high;
				end
			end
			i2c_pkg::tx_ack_high: begin
				scl_drive = 1'b1;
				if (phase_end) begin
					if (nak_q || last_q) begin
						state_next = i2c_pkg::tx_stop_a;
					end else begin
						state_next = i2c_pkg::tx_wait_byte;
					end
				end
			end
			i2c_pkg::tx_wait_byte: begin
				// SCL stays low until the host offers the next byte
				scl_drive = 1'b1;
				scl_level = 1'b0;
				if (tx_req && !tx_ack) begin
					load_tx = 1'b1;
					count_clear = 1'b1;
					state_next = i2c_pkg::tx_bit_low;
				end
			end
			i2c_pkg::tx_stop_a: begin
				scl_drive = 1'b1;
				scl_level = 1'b0;
				sda_drive = 1'b1;
				sda_level = 1'b0;
				if (phase_end) begin
					state_next = i2c_pkg::tx_stop_b;
				end
			end
			i2c_pkg::tx_stop_b: begin
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				sda_level = 1'b0;
				if (phase_end) begin
					state_next = i2c_pkg::tx_stop_c;
				end
			end
			i2c_pkg::tx_stop_c: begin
				scl_drive = 1'b1;
				sda_drive = 1'b1;
				if (phase_end) begin
					state_next = i2c_pkg::tx_result;
				end
			end
			i2c_pkg::tx_result: begin
				if (!result_req && !result_ack) begin
					state_next = i2c_pkg::idle;
				end
			end
			i2c_pkg::rx_bit: begin
				if (stop_seen) begin
					state_next = i2c_pkg::idle;
				end else if (scl_rise) begin
					shift_rx = 1'b1;
					if (bit_index == 3'd7) begin
						state_next = i2c_pkg::rx_ack;
					end
				end
			end
			i2c_pkg::rx_ack: begin
				if (stop_seen) begin
					state_next = i2c_pkg::idle;
				end else if (scl_fall && ack_phase) begin
					count_clear = 1'b1;
					if (rx_req || rx_ack) begin
						state_next = i2c_pkg::rx_hold;
					end else begin
						state_next = i2c_pkg::rx_bit;
					end
				end
			end
			i2c_pkg::rx_hold: begin
				// Stretch SCL until the host has finished with the last byte
				scl_drive = 1'b1;
				scl_level = 1'b0;
				if (!rx_req && !rx_ack) begin
					state_next = i2c_pkg::rx_bit;
				end
			end
			default: begin
				state_next = i2c_pkg::idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= i2c_pkg::idle;
			start_half <= 1'b0;
			tx_ack <= 1'b0;
			last_q <= 1'b0;
			nak_q <= 1'b0;
			ack_count <= '0;
			result_req <= 1'b0;
			rx_req <= 1'b0;
			rx_first <= 1'b0;
			first_q <= 1'b0;
			matched_q <= 1'b0;
			ack_phase <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			state <= state_next;
			byte_done <= shift_rx && (bit_index == 3'd7);

			if (state != i2c_pkg::tx_start) begin
				start_half <= 1'b0;
			end else if (phase_end) begin
				start_half <= 1'b1;
			end

			if (load_tx) begin
				tx_ack <= 1'b1;
				last_q <= tx_last;
			end else if (!tx_req) begin
				tx_ack <= 1'b0;
			end

			// The frame outcome builds up over the acknowledge bits
			if (state == i2c_pkg::idle) begin
				nak_q <= 1'b0;
				ack_count <= '0;
			end else if (state == i2c_pkg::tx_ack_low && phase_end) begin
				if (sda_now) begin
					nak_q <= 1'b1;
				end else begin
					ack_count <= ack_count + 1'b1;
				end
			end

			if (state == i2c_pkg::tx_stop_c && phase_end) begin
				result_req <= 1'b1;
			end else if (result_ack) begin
				result_req <= 1'b0;
			end

			if (state == i2c_pkg::idle && start_seen) begin
				first_q <= 1'b1;
				matched_q <= 1'b0;
			end else if (byte_done) begin
				first_q <= 1'b0;
				if (first_q) begin
					matched_q <= addr_enabled;
				end
			end

			// Deliver the address only when enabled, and data only after a match
			if (byte_done && (first_q ? addr_enabled : matched_q)) begin
				rx_req <= 1'b1;
				rx_first <= first_q;
			end else if (rx_ack) begin
				rx_req <= 1'b0;
			end

			if (state != i2c_pkg::rx_ack) begin
				ack_phase <= 1'b0;
			end else if (scl_fall) begin
				ack_phase <= 1'b1;
			end
		end
	end

	// Before the eighth shift the low seven bits hold the whole address
	always_ff @(posedge clk) begin
		if (shift_rx && bit_index == 3'd7 && first_q) begin
			lookup_addr <= rx_byte[6:0];
		end
	end

	assign phase_restart = (state_next != state) ||
		(state == i2c_pkg::tx_start && phase_end && !start_half);
	assign ack_hold = (state == i2c_pkg::rx_ack) && ack_phase && matched_q;
	assign tx_byte = tx_data;
	assign rx_data = rx_byte;
	assign result_code = nak_q ? i2c_pkg::res_nak : i2c_pkg::res_ack;
	assign result_count = ack_count;

endmodule

`default_nettype wire

/* design/i2c_discrete_top.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_discrete_top (
	input wire clk,
	input wire reset,
	input wire tx_req,
	input wire [7:0] tx_data,
	input wire tx_last,
	output logic tx_ack,
	output logic result_req,
	output i2c_pkg::result_e result_code,
	output logic [i2c_pkg::count_bits-1:0] result_count,
	input wire result_ack,
	output logic rx_req,
	output logic [7:0] rx_data,
	output logic rx_first,
	input wire rx_ack,
	input wire cfg_req,
	input wire [$clog2(i2c_pkg::addr_rows)-1:0] cfg_row,
	input wire [i2c_pkg::row_bits-1:0] cfg_data,
	output logic cfg_ack,
	input wire scl_pin,
	input wire sda_pin,
	output logic scl_pd,
	output logic scl_pu,
	output logic scl_tri,
	output logic sda_pd,
	output logic sda_pu,
	output logic sda_tri
);

	logic scl_now;
	logic sda_now;
	logic scl_rise;
	logic scl_fall;
	logic start_seen;
	logic stop_seen;
	logic phase_restart;
	logic phase_end;
	logic phase_quarter;
	logic load_tx;
	logic [7:0] tx_byte;
	logic shift_tx;
	logic shift_rx;
	logic count_clear;
	logic tx_bit;
	logic [7:0] rx_byte;
	logic [2:0] bit_index;
	logic [6:0] lookup_addr;
	logic addr_enabled;
	logic scl_drive;
	logic scl_level;
	logic sda_drive;
	logic sda_level;
	logic ack_hold;

	i2c_control control (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.tx_data(tx_data),
		.tx_last(tx_last),
		.result_ack(result_ack),
		.rx_ack(rx_ack),
		.scl_now(scl_now),
		.sda_now(sda_now),
		.scl_rise(scl_rise),
		.scl_fall(scl_fall),
		.start_seen(start_seen),
		.stop_seen(stop_seen),
		.phase_end(phase_end),
		.phase_quarter(phase_quarter),
		.tx_bit(tx_bit),
		.rx_byte(rx_byte),
		.bit_index(bit_index),
		.addr_enabled(addr_enabled),
		.tx_ack(tx_ack),
		.result_req(result_req),
		.result_code(result_code),
		.result_count(result_count),
		.rx_req(rx_req),
		.rx_data(rx_data),
		.rx_first(rx_first),
		.phase_restart(phase_restart),
		.load_tx(load_tx),
		.tx_byte(tx_byte),
		.shift_tx(shift_tx),
		.shift_rx(shift_rx),
		.count_clear(count_clear),
		.scl_drive(scl_drive),
		.scl_level(scl_level),
		.sda_drive(sda_drive),
		.sda_level(sda_level),
		.ack_hold(ack_hold),
		.lookup_addr(lookup_addr)
	);

	line_sampler sampler (
		.clk(clk),
		.reset(reset),
		.scl_pin(scl_pin),
		.sda_pin(sda_pin),
		.scl_now(scl_now),
		.sda_now(sda_now),
		.scl_rise(scl_rise),
		.scl_fall(scl_fall),
		.start_seen(start_seen),
		.stop_seen(stop_seen)
	);

	bit_timer timer (
		.clk(clk),
		.reset(reset),
		.phase_restart(phase_restart),
		.phase_end(phase_end),
		.phase_quarter(phase_quarter)
	);

	byte_shifter shifter (
		.clk(clk),
		.reset(reset),
		.load_tx(load_tx),
		.tx_byte(tx_byte),
		.shift_tx(shift_tx),
		.shift_rx(shift_rx),
		.count_clear(count_clear),
		.sda_now(sda_now),
		.tx_bit(tx_bit),
		.rx_byte(rx_byte),
		.bit_index(bit_index)
	);

	addr_table table_inst (
		.clk(clk),
		.reset(reset),
		.cfg_req(cfg_req),
		.cfg_row(cfg_row),
		.cfg_data(cfg_data),
		.lookup_addr(lookup_addr),
		.cfg_ack(cfg_ack),
		.addr_enabled(addr_enabled)
	);

	pad_driver pads (
		.clk(clk),
		.reset(reset),
		.scl_drive(scl_drive),
		.scl_level(scl_level),
		.sda_drive(sda_drive),
		.sda_level(sda_level),
		.ack_hold(ack_hold),
		.phase_quarter(phase_quarter),
		.scl_pd(scl_pd),
		.scl_pu(scl_pu),
		.scl_tri(scl_tri),
		.sda_pd(sda_pd),
		.sda_pu(sda_pu),
		.sda_tri(sda_tri)
	);

endmodule

`default_nettype wire

/* tests/i2c_discrete_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_discrete_assertions (
	input wire clk,
	input wire reset,
	input wire tx_req,
	input wire tx_ack,
	input wire result_req,
	input wire result_ack,
	input wire rx_req,
	input wire rx_ack
);

	// A request stays up until its acknowledge has been seen
	// A byte still on offer when the frame result arrives is withdrawn by the host
	tx_req_held: assert property (@(posedge clk) disable iff (reset)
		tx_req && !tx_ack && !result_req |=> tx_req)
		else $error("tx_req dropped before tx_ack");

	result_req_held: assert property (@(posedge clk) disable iff (reset)
		result_req && !result_ack |=> result_req)
		else $error("result_req dropped before result_ack");

	rx_req_held: assert property (@(posedge clk) disable iff (reset)
		rx_req && !rx_ack |=> rx_req)
		else $error("rx_req dropped before rx_ack");

endmodule

bind i2c_control i2c_discrete_assertions checks (
	.clk(clk),
	.reset(reset),
	.tx_req(tx_req),
	.tx_ack(tx_ack),
	.result_req(result_req),
	.result_ack(result_ack),
	.rx_req(rx_req),
	.rx_ack(rx_ack)
);

`default_nettype wire

/* tests/i2c_discrete_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_discrete_tb;

	localparam int num_entries = 6;
	localparam int op_master = 0;
	localparam int op_target = 1;
	// Bus-model master timing, slower than the DUT's own phases
	localparam int m_half = 40;
	localparam int m_quarter = 10;
	localparam int host_hold = 240;

	logic clk;
	logic reset;
	logic tx_req;
	logic [7:0] tx_data;
	logic tx_last;
	logic tx_ack;
	logic result_req;
	i2c_pkg::result_e result_code;
	logic [i2c_pkg::count_bits-1:0] result_count;
	logic result_ack;
	logic rx_req;
	logic [7:0] rx_data;
	logic rx_first;
	logic rx_ack;
	logic cfg_req;
	logic [3:0] cfg_row;
	logic [7:0] cfg_data;
	logic cfg_ack;
	wire scl_pin;
	wire sda_pin;
	logic scl_pd;
	logic scl_pu;
	logic scl_tri;
	logic sda_pd;
	logic sda_pu;
	logic sda_tri;

	// Pulls of the testbench's own bus device
	logic tb_scl_low;
	logic tb_sda_low;

	// Stimulus table
	int op_tab [num_entries];
	logic [6:0] addr_tab [num_entries];
	int nbytes_tab [num_entries];
	int nak_tab [num_entries];
	logic en_tab [num_entries];
	i2c_pkg::result_e exp_tab [num_entries];
	logic [7:0] data_tab [num_entries][4];
	logic table_ready;

	logic [31:0] lfsr_state;
	logic [7:0] frame [8];
	logic scl_cur;
	logic scl_prev;
	logic sda_cur;
	logic sda_prev;
	logic saw_stop;
	logic stretched;
	logic master_done;
	logic addr_acked;
	int data_naks;
	logic [7:0] seen_bytes [$];
	logic [7:0] rx_got [$];
	logic rx_first_got [$];
	i2c_pkg::result_e got_code;
	logic [7:0] got_count;
	int errors;
	int tests_run;
	int tests_failed;
	int watch_ns;

	i2c_discrete_top uut (
		.clk(clk), .reset(reset),
		.tx_req(tx_req), .tx_data(tx_data), .tx_last(tx_last), .tx_ack(tx_ack),
		.result_req(result_req), .result_code(result_code),
		.result_count(result_count), .result_ack(result_ack),
		.rx_req(rx_req), .rx_data(rx_data), .rx_first(rx_first), .rx_ack(rx_ack),
		.cfg_req(cfg_req), .cfg_row(cfg_row), .cfg_data(cfg_data), .cfg_ack(cfg_ack),
		.scl_pin(scl_pin), .sda_pin(sda_pin),
		.scl_pd(scl_pd), .scl_pu(scl_pu), .scl_tri(scl_tri),
		.sda_pd(sda_pd), .sda_pu(sda_pu), .sda_tri(sda_tri)
	);

	// Open-drain bus, a line is low when anyone pulls it
	assign scl_pin = !((scl_pd && scl_tri) || tb_scl_low);
	assign sda_pin = !((sda_pd && sda_tri) || tb_sda_low);

	always #4 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic sample_bus();
		@(negedge clk);
		scl_prev = scl_cur;
		sda_prev = sda_cur;
		scl_cur = scl_pin;
		sda_cur = sda_pin;
	endtask

	task automatic wait_scl(input logic level);
		do sample_bus(); while (scl_cur != level);
	endtask

	task automatic load_row(input logic [3:0] row, input logic [7:0] bits);
		@(posedge clk);
		cfg_req <= 1'b1;
		cfg_row <= row;
		cfg_data <= bits;
		do @(negedge clk); while (!cfg_ack);
		@(posedge clk);
		cfg_req <= 1'b0;
		do @(negedge clk); while (cfg_ack);
	endtask

	// Host side of a master frame, stops offering bytes once the result shows up
	task automatic send_frame(input int n);
		logic stop_early;
		stop_early = 1'b0;
		for (int i = 0; i < n && !stop_early; i++) begin
			@(posedge clk);
			tx_req <= 1'b1;
			tx_data <= frame[i];
			tx_last <= (i == n - 1);
			do @(negedge clk); while (!tx_ack && !result_req);
			if (result_req) stop_early = 1'b1;
			@(posedge clk);
			tx_req <= 1'b0;
			do @(negedge clk); while (tx_ack);
		end
		while (!result_req) @(negedge clk);
		got_code = result_code;
		got_count = result_count;
		@(posedge clk);
		result_ack <= 1'b1;
		do @(negedge clk); while (result_req);
		@(posedge clk);
		result_ack <= 1'b0;
	endtask

	// Bus-model target, collects bytes and refuses the one at nak_pos
	task automatic act_as_target(input int nak_pos);
		int idx;
		int b;
		logic [7:0] val;
		logic ended;
		logic start_found;
		seen_bytes.delete();
		saw_stop = 1'b0;
		start_found = 1'b0;
		ended = 1'b0;
		idx = 0;
		scl_cur = scl_pin;
		sda_cur = sda_pin;
		while (!start_found) begin
			sample_bus();
			if (scl_cur && scl_prev && sda_prev && !sda_cur) start_found = 1'b1;
		end
		while (!ended) begin
			val = 8'h00;
			b = 0;
			while (b < 8 && !ended) begin
				sample_bus();
				if (scl_cur && scl_prev && sda_cur && !sda_prev) begin
					ended = 1'b1;
					saw_stop = 1'b1;
				end else if (scl_cur && !scl_prev) begin
					val = {val[6:0], sda_cur};
					b++;
				end
			end
			if (!ended) begin
				seen_bytes.push_back(val);
				wait_scl(1'b0);
				if (idx != nak_pos) begin
					@(posedge clk);
					tb_sda_low <= 1'b1;
				end
				wait_scl(1'b1);
				wait_scl(1'b0);
				@(posedge clk);
				tb_sda_low <= 1'b0;
				idx++;
			end
		end
	endtask

	// Lets SCL go and waits for it, noting when the DUT holds it low
	task automatic release_scl();
		int cnt;
		@(posedge clk);
		tb_scl_low <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!scl_pin);
		if (cnt > 2) stretched = 1'b1;
	endtask

	task automatic master_send_byte(input logic [7:0] b, output logic acked);
		for (int i = 7; i >= 0; i--) begin
			wait_cycles(m_quarter);
			tb_sda_low <= ~b[i];
			wait_cycles(m_half - m_quarter);
			release_scl();
			wait_cycles(m_half);
			tb_scl_low <= 1'b1;
		end
		wait_cycles(m_quarter);
		tb_sda_low <= 1'b0;
		wait_cycles(m_half - m_quarter);
		release_scl();
		wait_cycles(m_half / 2);
		@(negedge clk);
		acked = !sda_pin;
		wait_cycles(m_half / 2);
		tb_scl_low <= 1'b1;
	endtask

	task automatic act_as_master(input int n);
		logic acked;
		stretched = 1'b0;
		data_naks = 0;
		wait_cycles(m_half);
		tb_sda_low <= 1'b1;
		wait_cycles(m_half);
		tb_scl_low <= 1'b1;
		master_send_byte(frame[0], acked);
		addr_acked = acked;
		if (acked) begin
			for (int i = 1; i <= n; i++) begin
				master_send_byte(frame[i], acked);
				if (!acked) data_naks++;
			end
		end
		// STOP, SCL may be stretched before it can rise
		wait_cycles(m_quarter);
		tb_sda_low <= 1'b1;
		wait_cycles(m_half - m_quarter);
		release_scl();
		wait_cycles(m_half);
		tb_sda_low <= 1'b0;
		wait_cycles(m_half);
	endtask

	// Host side of the rx channel, slow on purpose so the DUT has to stretch
	task automatic serve_rx();
		rx_got.delete();
		rx_first_got.delete();
		while (!(master_done && !rx_req)) begin
			@(negedge clk);
			if (rx_req) begin
				rx_got.push_back(rx_data);
				rx_first_got.push_back(rx_first);
				wait_cycles(host_hold);
				rx_ack <= 1'b1;
				do @(negedge clk); while (rx_req);
				@(posedge clk);
				rx_ack <= 1'b0;
			end
		end
	endtask

	initial begin
		table_ready = 1'b0;
		op_tab = '{op_master, op_master, op_master, op_target, op_target, op_target};
		addr_tab = '{7'h50, 7'h21, 7'h3c, 7'h2a, 7'h13, 7'h13};
		nbytes_tab = '{3, 4, 2, 3, 2, 2};
		nak_tab = '{-1, 2, 0, -1, -1, -1};
		en_tab = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
		exp_tab = '{i2c_pkg::res_ack, i2c_pkg::res_nak, i2c_pkg::res_nak,
			i2c_pkg::res_ack, i2c_pkg::res_nak, i2c_pkg::res_ack};
		lfsr_state = 32'h1437;
		for (int e = 0; e < num_entries; e++) begin
			for (int i = 0; i < 4; i++) begin
				random_byte(data_tab[e][i]);
			end
		end
		table_ready = 1'b1;
	end

	// Watchdog sized from the table, with room for the slow bus-model master
	initial begin
		wait (table_ready);
		watch_ns = 20000;
		for (int e = 0; e < num_entries; e++) begin
			watch_ns += (nbytes_tab[e] + 1) * 20 * int'(i2c_pkg::half_bit) * 8 * 4;
		end
		#(watch_ns);
		$display("watchdog expired after %0d ns without finishing", watch_ns);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		int n;
		int exp_seen;
		int exp_cnt;
		int err_before;
		string name;
		clk = 1'b0;
		reset = 1'b1;
		tx_req = 1'b0;
		tx_data = 8'h00;
		tx_last = 1'b0;
		result_ack = 1'b0;
		rx_ack = 1'b0;
		cfg_req = 1'b0;
		cfg_row = 4'h0;
		cfg_data = 8'h00;
		tb_scl_low = 1'b0;
		tb_sda_low = 1'b0;
		master_done = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		wait (table_ready);
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// Quiet outputs after reset, before any request
		err_before = errors;
		repeat (8) begin
			@(negedge clk);
			if ({tx_ack, result_req, rx_req, cfg_ack} != 4'h0) begin
				$display("mismatch handshake outputs: got %h expected %h",
					{tx_ack, result_req, rx_req, cfg_ack}, 4'h0);
				errors++;
			end
			if ({scl_pd, scl_pu, scl_tri, sda_pd, sda_pu, sda_tri} != 6'h00) begin
				$display("mismatch pad controls: got %h expected %h",
					{scl_pd, scl_pu, scl_tri, sda_pd, sda_pu, sda_tri}, 6'h00);
				errors++;
			end
		end
		tests_run++;
		if (errors != err_before) tests_failed++;
		$display("reset state: %s", (errors == err_before) ? "pass" : "fail");

		for (int e = 0; e < num_entries; e++) begin
			err_before = errors;
			n = nbytes_tab[e];
			frame[0] = {addr_tab[e], 1'b0};
			for (int i = 0; i < n; i++) frame[i + 1] = data_tab[e][i];
			if (op_tab[e] == op_master) begin
				name = (nak_tab[e] < 0) ? "master write" : "master nak";
				fork
					send_frame(n + 1);
					act_as_target(nak_tab[e]);
				join
				exp_seen = (nak_tab[e] < 0) ? n + 1 : nak_tab[e] + 1;
				exp_cnt = (nak_tab[e] < 0) ? n + 1 : nak_tab[e];
				if (!saw_stop) begin
					$display("no STOP was seen on the bus after the frame");
					errors++;
				end
				if (seen_bytes.size() != exp_seen) begin
					$display("mismatch bytes on bus: got %h expected %h",
						seen_bytes.size(), exp_seen);
					errors++;
				end else begin
					for (int i = 0; i < exp_seen; i++) begin
						if (seen_bytes[i] != frame[i]) begin
							$display("mismatch bus byte %0d: got %h expected %h",
								i, seen_bytes[i], frame[i]);
							errors++;
						end
					end
				end
				if (got_code != exp_tab[e]) begin
					$display("mismatch result_code: got %h expected %h", got_code, exp_tab[e]);
					errors++;
				end
				if (got_count != 8'(exp_cnt)) begin
					$display("mismatch result_count: got %h expected %h",
						got_count, 8'(exp_cnt));
					errors++;
				end
			end else begin
				name = en_tab[e] ? "target receive" : "target disabled";
				load_row(addr_tab[e][6:3], en_tab[e] ? (8'h01 << addr_tab[e][2:0]) : 8'h00);
				master_done = 1'b0;
				fork
					begin
						act_as_master(n);
						master_done = 1'b1;
					end
					serve_rx();
				join
				if (addr_acked != (exp_tab[e] == i2c_pkg::res_ack)) begin
					$display("mismatch address ack: got %h expected %h",
						addr_acked, exp_tab[e] == i2c_pkg::res_ack);
					errors++;
				end
				if (!en_tab[e] && rx_got.size() != 0) begin
					$display("mismatch rx_req count: got %h expected %h", rx_got.size(), 0);
					errors++;
				end
				if (en_tab[e]) begin
					if (data_naks != 0) begin
						$display("the DUT refused %0d data bytes", data_naks);
						errors++;
					end
					if (!stretched) begin
						$display("SCL was never held low while the host was slow");
						errors++;
					end
					if (rx_got.size() != n + 1) begin
						$display("mismatch rx bytes: got %h expected %h", rx_got.size(), n + 1);
						errors++;
					end else begin
						for (int i = 0; i <= n; i++) begin
							if (rx_got[i] != frame[i]) begin
								$display("mismatch rx_data %0d: got %h expected %h",
									i, rx_got[i], frame[i]);
								errors++;
							end
							if (rx_first_got[i] != (i == 0)) begin
								$display("mismatch rx_first %0d: got %h expected %h",
									i, rx_first_got[i], i == 0);
								errors++;
							end
						end
					end
				end
			end
			wait_cycles(4 * int'(i2c_pkg::half_bit));
			tests_run++;
			if (errors != err_before) tests_failed++;
			$display("entry %0d %s: %s", e, name, (errors == err_before) ? "pass" : "fail");
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
design/i2c_pkg.sv
design/line_sampler.sv
design/bit_timer.sv
design/byte_shifter.sv
design/addr_table.sv
design/pad_driver.sv
design/i2c_control.sv
design/i2c_discrete_top.sv
tests/i2c_discrete_assertions.sv
tests/i2c_discrete_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module i2c_discrete_tb -o i2c_sim
./obj_dir/i2c_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
	exit 0
fi
exit 1
